/* design/snoop_pkg.sv */
/* Shared widths, bus structs and register map for the packet snooper.
   Stream and buffer share one 64-bit width, and the buffer holds 256 words. */

`default_nettype none

package snoop_pkg;

    // Stream and buffer widths
    localparam int SN_DATA_W  = 64;
    localparam int SN_KEEP_W  = SN_DATA_W / 8;
    localparam int BUF_ADDR_W = 8;
    localparam int BUF_DEPTH  = 1 << BUF_ADDR_W;
    // Byte count of one packet, up to BUF_DEPTH * 8 bytes
    localparam int LEN_W      = 12;

    // Wishbone widths
    localparam int WB_DATA_W  = 32;
    localparam int WB_ADDR_W  = 12;
    localparam int WB_SEL_W   = WB_DATA_W / 8;

    // One observed stream beat
    typedef struct packed {
        logic [SN_DATA_W-1:0] tdata;
        logic [SN_KEEP_W-1:0] tkeep;
        logic                 tlast;
    } axis_beat_t;

    // Snooper write into the buffer, byte_len valid only with done
    typedef struct packed {
        logic                  wr_en;
        logic [BUF_ADDR_W-1:0] addr;
        logic [SN_DATA_W-1:0]  data;
        logic                  done;
        logic [LEN_W-1:0]      byte_len;
    } snoop_wr_t;

    // Wishbone classic request from the host
    typedef struct packed {
        logic                 cyc;
        logic                 stb;
        logic                 we;
        logic [WB_ADDR_W-1:0] adr;
        logic [WB_DATA_W-1:0] dat_w;
        logic [WB_SEL_W-1:0]  sel;
    } wb_req_t;

    // Wishbone classic response
    typedef struct packed {
        logic                 ack;
        logic [WB_DATA_W-1:0] dat_r;
    } wb_rsp_t;

    // Register map, byte addresses
    localparam logic [WB_ADDR_W-1:0] REG_STATUS = 12'h000;
    localparam logic [WB_ADDR_W-1:0] REG_DROPS  = 12'h004;
    localparam logic [WB_ADDR_W-1:0] REG_CTRL   = 12'h008;
    // Buffer word n at BUF_WINDOW + 8n, low half first
    localparam logic [WB_ADDR_W-1:0] BUF_WINDOW = 12'h800;

endpackage

`default_nettype wire

/* design/axis_snooper.sv */
/* Passive AXI-stream snooper, never stalls the link. Capture starts only on a
   packet boundary with the buffer free. Packets over 256 beats are not supported,
   and TKEEP must be contiguous from byte 0 and is used on the last beat only. */

`timescale 1ns/10ps
`default_nettype none

module axis_snooper
    import snoop_pkg::*;
#(
    parameter int REG_IN = 0
) (
    input  logic       clk,
    input  logic       rst,
    input  axis_beat_t beat_i,
    input  logic       tvalid_i,
    input  logic       tready_i,
    input  logic       buf_free_i,
    output snoop_wr_t  wr_o,
    output logic       drop_pulse_o
);

    typedef enum logic [1:0] {
        IDLE,
        ALIGN,
        CAPTURE
    } state_t;

    state_t                state_q;
    state_t                state_d;
    axis_beat_t            beat_s;
    logic                  valid_s;
    logic                  ready_s;
    logic                  beat_ok;
    logic                  last_ok;
    logic                  wr_en;
    logic [BUF_ADDR_W-1:0] addr_q;
    logic [LEN_W-1:0]      len_q;

    // Count of set TKEEP bits
    function automatic logic [LEN_W-1:0] keep_bytes(input logic [SN_KEEP_W-1:0] keep);
        logic [LEN_W-1:0] n;
        n = '0;
        for (int i = 0; i < SN_KEEP_W; i++) begin
            n = n + LEN_W'(keep[i]);
        end
        return n;
    endfunction

    // Optional input register, adds one cycle to write and drop pulse
    if (REG_IN != 0) begin : g_reg_in
        axis_beat_t beat_r;
        logic       valid_r;
        logic       ready_r;

        always_ff @(posedge clk) begin
            if (rst) begin
                valid_r <= 1'b0;
            end else begin
                valid_r <= tvalid_i;
            end
            beat_r  <= beat_i;
            ready_r <= tready_i;
        end

        assign beat_s  = beat_r;
        assign valid_s = valid_r;
        assign ready_s = ready_r;
    end else begin : g_no_reg
        assign beat_s  = beat_i;
        assign valid_s = tvalid_i;
        assign ready_s = tready_i;
    end

    // A beat only counts when the link itself transfers it
    assign beat_ok = valid_s & ready_s;
    assign last_ok = beat_ok & beat_s.tlast;
    assign wr_en   = beat_ok & (state_q == CAPTURE);

    always_comb begin
        state_d = state_q;
        case (state_q)
            // Buffer free, so look for the next boundary
            // A last beat in this same cycle is itself the boundary
            IDLE: begin
                if (buf_free_i) begin
                    state_d = last_ok ? CAPTURE : ALIGN;
                end
            end
            // Skip the rest of a packet already under way
            ALIGN: begin
                if (last_ok) begin
                    state_d = CAPTURE;
                end
            end
            // The packet just ended fills the single buffer
            // Wait in IDLE until the host releases it
            CAPTURE: begin
                if (last_ok) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= IDLE;
            addr_q  <= '0;
            len_q   <= '0;
        end else begin
            state_q <= state_d;
            if (wr_en) begin
                if (beat_s.tlast) begin
                    addr_q <= '0;
                    len_q  <= '0;
                end else begin
                    addr_q <= addr_q + BUF_ADDR_W'(1);
                    len_q  <= len_q + LEN_W'(SN_KEEP_W);
                end
            end
        end
    end

    // Write goes out in the same cycle as the counted beat
    always_comb begin
        wr_o.wr_en    = wr_en;
        wr_o.addr     = addr_q;
        wr_o.data     = beat_s.tdata;
        wr_o.done     = wr_en & beat_s.tlast;
        // Full beats so far plus the bytes of this one
        wr_o.byte_len = len_q + keep_bytes(beat_s.tkeep);
    end

    // Lost packet, seen ending while not capturing
    assign drop_pulse_o = last_ok & (state_q != CAPTURE);

endmodule

`default_nettype wire

/* design/packet_buffer.sv */
/* Single packet buffer, 256 words of 64 bits with a one-cycle read port.
   Holds one packet until released, snooper writes are ignored while full. */

`timescale 1ns/10ps
`default_nettype none

module packet_buffer
    import snoop_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  snoop_wr_t             wr_i,
    input  logic                  release_i,
    input  logic [BUF_ADDR_W-1:0] rd_addr_i,
    output logic [SN_DATA_W-1:0]  rd_data_o,
    output logic                  full_o,
    output logic [LEN_W-1:0]      stored_len_o,
    output logic                  buf_free_o
);

    logic [SN_DATA_W-1:0] mem [BUF_DEPTH];
    logic                 full_q;
    logic                 wr_ok;
    logic                 done_ok;
    logic [LEN_W-1:0]     len_q;
    logic [SN_DATA_W-1:0] rd_data_q;

    // Stored packet is protected until the host releases it
    assign wr_ok   = wr_i.wr_en & ~full_q;
    assign done_ok = wr_ok & wr_i.done;

    // Simple dual port, write from the snooper, read from the host
    always_ff @(posedge clk) begin
        if (wr_ok) begin
            mem[wr_i.addr] <= wr_i.data;
        end
        rd_data_q <= mem[rd_addr_i];
    end

    // Full on the edge that takes done
    // done and release never meet, done only arrives while not full
    always_ff @(posedge clk) begin
        if (rst) begin
            full_q <= 1'b0;
        end else if (done_ok) begin
            full_q <= 1'b1;
        end else if (release_i) begin
            full_q <= 1'b0;
        end
    end

    // Length of the packet in the buffer
    always_ff @(posedge clk) begin
        if (done_ok) begin
            len_q <= wr_i.byte_len;
        end
    end

    assign rd_data_o    = rd_data_q;
    assign full_o       = full_q;
    assign stored_len_o = len_q;
    // Falls only after done, so never in the middle of a capture
    assign buf_free_o   = ~full_q;

endmodule

`default_nettype wire

/* design/wb_snoop_regs.sv */
/* Wishbone classic slave for status, drop count, release and the buffer window.
   Every access is acked exactly one cycle after the request, with no wait states. */

`timescale 1ns/10ps
`default_nettype none

module wb_snoop_regs
    import snoop_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  wb_req_t               wb_req_i,
    output wb_rsp_t               wb_rsp_o,
    input  logic                  full_i,
    input  logic [LEN_W-1:0]      stored_len_i,
    input  logic                  drop_pulse_i,
    output logic [BUF_ADDR_W-1:0] rd_addr_o,
    input  logic [SN_DATA_W-1:0]  rd_data_i,
    output logic                  release_o
);

    logic                 req;
    logic                 win_hit;
    logic                 ctrl_wr;
    logic [WB_ADDR_W-1:0] reg_adr;
    logic [WB_DATA_W-1:0] reg_rdata;
    logic [WB_DATA_W-1:0] rdata_q;
    logic [WB_DATA_W-1:0] drops_q;
    logic                 ack_q;
    logic                 win_q;
    logic                 hi_q;
    logic                 release_q;

    // New request, the ack guard stops a second ack on a held strobe
    assign req = wb_req_i.cyc & wb_req_i.stb & ~ack_q;

    // Window fills the upper half of the address space
    assign win_hit = wb_req_i.adr[WB_ADDR_W-1];
    // Word aligned register address
    assign reg_adr = {wb_req_i.adr[WB_ADDR_W-1:2], 2'b00};

    // Release needs byte lane 0 and bit 0 set
    assign ctrl_wr = req & wb_req_i.we & (reg_adr == REG_CTRL)
                   & wb_req_i.sel[0] & wb_req_i.dat_w[0];

    // Register read mux
    always_comb begin
        reg_rdata = '0;
        case (reg_adr)
            // Length in 27:16, full flag in bit 0
            REG_STATUS: reg_rdata = {4'b0, stored_len_i, 15'b0, full_i};
            REG_DROPS:  reg_rdata = drops_q;
            default:    reg_rdata = '0;
        endcase
    end

    // Buffer word index from the window offset, 8 bytes per word
    // The RAM reads it on the same edge that raises ack
    assign rd_addr_o = wb_req_i.adr[BUF_ADDR_W+2:3];

    always_ff @(posedge clk) begin
        if (rst) begin
            ack_q     <= 1'b0;
            release_q <= 1'b0;
        end else begin
            ack_q     <= req;
            release_q <= ctrl_wr;
        end
    end

    // Read source and half select, captured with the ack
    always_ff @(posedge clk) begin
        if (req) begin
            rdata_q <= reg_rdata;
            win_q   <= win_hit;
            hi_q    <= wb_req_i.adr[2];
        end
    end

    // Lost packet counter, holds at its maximum
    always_ff @(posedge clk) begin
        if (rst) begin
            drops_q <= '0;
        end else if (drop_pulse_i && (drops_q != '1)) begin
            drops_q <= drops_q + WB_DATA_W'(1);
        end
    end

    always_comb begin
        wb_rsp_o.ack = ack_q;
        if (win_q) begin
            wb_rsp_o.dat_r = hi_q ? rd_data_i[SN_DATA_W-1:WB_DATA_W] : rd_data_i[WB_DATA_W-1:0];
        end else begin
            wb_rsp_o.dat_r = rdata_q;
        end
    end

    // High in the ack cycle, buffer frees on the closing edge
    assign release_o = release_q;

endmodule

`default_nettype wire

/* design/snoop_top.sv */
/* Packet snooper top level. The stream inputs are observed only, nothing here
   drives ready. REG_IN adds one input register stage in the snooper. */

`timescale 1ns/10ps
`default_nettype none

module snoop_top
    import snoop_pkg::*;
#(
    parameter int REG_IN = 0
) (
    input  logic       clk,
    input  logic       rst,
    input  axis_beat_t sn_beat_i,
    input  logic       sn_tvalid_i,
    input  logic       sn_tready_i,
    input  wb_req_t    wb_req_i,
    output wb_rsp_t    wb_rsp_o
);

    snoop_wr_t             snoop_wr;
    logic                  drop_pulse;
    logic                  buf_free;
    logic                  full;
    logic [LEN_W-1:0]      stored_len;
    logic                  release_buf;
    logic [BUF_ADDR_W-1:0] rd_addr;
    logic [SN_DATA_W-1:0]  rd_data;

    // Stream side, boundary aligned capture
    axis_snooper #(
        .REG_IN (REG_IN)
    ) u_snooper (
        .clk          (clk),
        .rst          (rst),
        .beat_i       (sn_beat_i),
        .tvalid_i     (sn_tvalid_i),
        .tready_i     (sn_tready_i),
        .buf_free_i   (buf_free),
        .wr_o         (snoop_wr),
        .drop_pulse_o (drop_pulse)
    );

    // One packet store
    packet_buffer u_buffer (
        .clk          (clk),
        .rst          (rst),
        .wr_i         (snoop_wr),
        .release_i    (release_buf),
        .rd_addr_i    (rd_addr),
        .rd_data_o    (rd_data),
        .full_o       (full),
        .stored_len_o (stored_len),
        .buf_free_o   (buf_free)
    );

    // Host side
    wb_snoop_regs u_regs (
        .clk          (clk),
        .rst          (rst),
        .wb_req_i     (wb_req_i),
        .wb_rsp_o     (wb_rsp_o),
        .full_i       (full),
        .stored_len_i (stored_len),
        .drop_pulse_i (drop_pulse),
        .rd_addr_o    (rd_addr),
        .rd_data_i    (rd_data),
        .release_o    (release_buf)
    );

endmodule

`default_nettype wire

/* verif/snoop_assert.sv */
/* Concurrent checks on the snooper write stream and the buffer full flag.
   Bound into the snooper and the buffer. The full flag check runs only in the
   buffer and the drop check only in the snooper. */

`timescale 1ns/10ps
`default_nettype none

module snoop_assert
    import snoop_pkg::*;
#(
    parameter bit CHECK_FULL = 1'b0
) (
    input logic      clk,
    input logic      rst,
    input snoop_wr_t wr_i,
    input logic      drop_i,
    input logic      full_i,
    input logic      release_i
);

    // Beats written so far in the current packet
    logic [BUF_ADDR_W:0] beat_idx;

    always_ff @(posedge clk) begin
        if (rst) begin
            beat_idx <= '0;
        end else if (wr_i.wr_en) begin
            beat_idx <= wr_i.done ? '0 : beat_idx + (BUF_ADDR_W+1)'(1);
        end
    end

    a_done_wr: assert property (@(posedge clk) disable iff (rst)
        wr_i.done |-> wr_i.wr_en)
        else $error("done raised without a buffer write");

    // Drop pulse exists only in the snooper
    if (!CHECK_FULL) begin : g_drop
        a_drop_done: assert property (@(posedge clk) disable iff (rst)
            !(drop_i && wr_i.done))
            else $error("drop pulse and done high in the same cycle");
    end

    // Address never runs ahead of the beat index
    a_addr_idx: assert property (@(posedge clk) disable iff (rst)
        wr_i.wr_en |-> ({1'b0, wr_i.addr} <= beat_idx))
        else $error("write address beyond the packet beat index");

    if (CHECK_FULL) begin : g_full
        a_full_rel: assert property (@(posedge clk) disable iff (rst)
            $fell(full_i) |-> $past(release_i))
            else $error("full flag fell without a release");
    end

endmodule

bind axis_snooper snoop_assert #(
    .CHECK_FULL (1'b0)
) u_assert (
    .clk       (clk),
    .rst       (rst),
    .wr_i      (wr_o),
    .drop_i    (drop_pulse_o),
    .full_i    (~buf_free_i),
    .release_i (1'b0)
);

bind packet_buffer snoop_assert #(
    .CHECK_FULL (1'b1)
) u_assert (
    .clk       (clk),
    .rst       (rst),
    .wr_i      (wr_i),
    .drop_i    (1'b0),
    .full_i    (full_q),
    .release_i (release_i)
);

`default_nettype wire

/* verif/snoop_tb.sv */
/* Directed testbench for the packet snooper, input register stage enabled.
   Stream beats are never stalled by the DUT, ready stalls come from the LFSR. */

`timescale 1ns/10ps
`default_nettype none

module snoop_tb
    import snoop_pkg::*;
();

    localparam logic [31:0] LFSR_SEED    = 32'ha468_a90d;
    localparam logic [31:0] LFSR_TAPS    = 32'h8020_0003;
    localparam int          ACK_TIMEOUT  = 20;
    localparam int          POLL_TIMEOUT = 50;

    logic       clk;
    logic       rst;
    axis_beat_t beat;
    logic       tvalid;
    logic       tready;
    wb_req_t    wb_req;
    wb_rsp_t    wb_rsp;

    logic [31:0]          lfsr_q;
    logic [SN_DATA_W-1:0] sent_q[$];
    logic [SN_DATA_W-1:0] stored_q[$];
    logic [LEN_W-1:0]     stored_len;
    logic [WB_DATA_W-1:0] exp_drops;
    int                   n_checks;
    int                   n_errors;
    int                   n_tests;
    int                   n_failed;
    int                   n_stalls;
    bit                   timed_out;

    snoop_top #(
        .REG_IN (1)
    ) UUT (
        .clk         (clk),
        .rst         (rst),
        .sn_beat_i   (beat),
        .sn_tvalid_i (tvalid),
        .sn_tready_i (tready),
        .wb_req_i    (wb_req),
        .wb_rsp_o    (wb_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Galois LFSR, one step per bit
    function automatic logic next_bit();
        logic b;
        b = lfsr_q[0];
        lfsr_q = {1'b0, lfsr_q[31:1]} ^ (b ? LFSR_TAPS : 32'h0);
        return b;
    endfunction

    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(next_bit());
        end
        return v;
    endfunction

    function automatic logic [SN_DATA_W-1:0] rand_word();
        logic [SN_DATA_W-1:0] w;
        w = '0;
        for (int i = 0; i < SN_DATA_W; i++) begin
            w = {w[SN_DATA_W-2:0], next_bit()};
        end
        return w;
    endfunction

    // Full beats before the last one, then the kept bytes of the last
    function automatic logic [LEN_W-1:0] expected_len(input int beats,
                                                      input logic [SN_KEEP_W-1:0] keep);
        return LEN_W'((beats - 1) * 8 + $countones(keep));
    endfunction

    task automatic check_data(input string what, input logic [SN_DATA_W-1:0] got,
                              input logic [SN_DATA_W-1:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("Error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_len(input string what, input logic [LEN_W-1:0] got,
                             input logic [LEN_W-1:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("Error at %0d ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_reg(input string what, input logic [WB_DATA_W-1:0] got,
                             input logic [WB_DATA_W-1:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("Error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // Sends one packet, stalled beats hold valid with ready low
    task automatic send_packet(input int beats, input logic [SN_KEEP_W-1:0] last_keep,
                               input bit with_stalls);
        axis_beat_t b;
        int         n_stall;
        sent_q.delete();
        for (int i = 0; i < beats; i++) begin
            b.tdata = rand_word();
            b.tlast = (i == beats - 1);
            b.tkeep = b.tlast ? last_keep : '1;
            n_stall = with_stalls ? rand_bits(2) : 0;
            for (int s = 0; s < n_stall; s++) begin
                @(posedge clk);
                beat   <= b;
                tvalid <= 1'b1;
                tready <= 1'b0;
                n_stalls++;
            end
            @(posedge clk);
            beat   <= b;
            tvalid <= 1'b1;
            tready <= 1'b1;
            sent_q.push_back(b.tdata);
        end
        @(posedge clk);
        tvalid <= 1'b0;
    endtask

    // One Wishbone classic cycle, held until ack
    task automatic wb_access(input logic we, input logic [WB_ADDR_W-1:0] adr,
                             input logic [WB_DATA_W-1:0] wdata,
                             output logic [WB_DATA_W-1:0] rdata);
        wb_req_t r;
        int      t;
        rdata = '0;
        if (!timed_out) begin
            r       = '0;
            r.cyc   = 1'b1;
            r.stb   = 1'b1;
            r.we    = we;
            r.adr   = adr;
            r.dat_w = wdata;
            r.sel   = '1;
            @(posedge clk);
            wb_req <= r;
            t = 0;
            do begin
                @(negedge clk);
                t++;
            end while (!wb_rsp.ack && t < ACK_TIMEOUT);
            if (wb_rsp.ack) begin
                rdata = wb_rsp.dat_r;
            end else begin
                $display("Timeout: no Wishbone ack for address %h", adr);
                timed_out = 1'b1;
            end
            @(posedge clk);
            wb_req <= '0;
        end
    endtask

    task automatic wb_read(input logic [WB_ADDR_W-1:0] adr,
                           output logic [WB_DATA_W-1:0] data);
        wb_access(1'b0, adr, '0, data);
    endtask

    task automatic wb_write(input logic [WB_ADDR_W-1:0] adr, input logic [WB_DATA_W-1:0] data);
        logic [WB_DATA_W-1:0] unused;
        wb_access(1'b1, adr, data, unused);
    endtask

    task automatic wait_drops(input logic [WB_DATA_W-1:0] target);
        logic [WB_DATA_W-1:0] v;
        int                   t;
        t = 0;
        wb_read(REG_DROPS, v);
        while (v != target && t < POLL_TIMEOUT && !timed_out) begin
            wb_read(REG_DROPS, v);
            t++;
        end
        if (v != target && !timed_out) begin
            $display("Timeout: drop count stayed at %0d, waiting for %0d", v, target);
            timed_out = 1'b1;
        end
    endtask

    task automatic wait_full();
        logic [WB_DATA_W-1:0] v;
        int                   t;
        t = 0;
        wb_read(REG_STATUS, v);
        while (!v[0] && t < POLL_TIMEOUT && !timed_out) begin
            wb_read(REG_STATUS, v);
            t++;
        end
        if (!v[0] && !timed_out) begin
            $display("Timeout: buffer never reported full");
            timed_out = 1'b1;
        end
    endtask

    // Status, length and every window word against the expected packet
    task automatic check_stored();
        logic [WB_DATA_W-1:0] status;
        logic [WB_DATA_W-1:0] lo;
        logic [WB_DATA_W-1:0] hi;
        wb_read(REG_STATUS, status);
        check_reg("full flag", {31'b0, status[0]}, 32'd1);
        check_len("stored length", status[27:16], stored_len);
        foreach (stored_q[i]) begin
            wb_read(BUF_WINDOW + WB_ADDR_W'(8 * i), lo);
            wb_read(BUF_WINDOW + WB_ADDR_W'(8 * i + 4), hi);
            check_data($sformatf("buffer word %0d", i), {hi, lo}, stored_q[i]);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        n_tests++;
        if (n_errors == errs_before && !timed_out) begin
            $display("Test %s: ok", name);
        end else begin
            n_failed++;
            $display("Test %s: %0d errors", name, n_errors - errs_before);
        end
    endtask

    task automatic test_first_drop();
        logic [WB_DATA_W-1:0] status;
        int                   errs;
        errs = n_errors;
        send_packet(3, 8'hff, 1'b0);
        exp_drops = exp_drops + 32'd1;
        wait_drops(exp_drops);
        wb_read(REG_STATUS, status);
        check_reg("full flag", {31'b0, status[0]}, 32'd0);
        report_test("first packet dropped", errs);
    endtask

    task automatic test_capture();
        logic [WB_DATA_W-1:0] v;
        int                   errs;
        errs = n_errors;
        send_packet(5, 8'h07, 1'b0);
        stored_q   = sent_q;
        stored_len = expected_len(5, 8'h07);
        wait_full();
        check_stored();
        wb_read(REG_DROPS, v);
        check_reg("drop count", v, exp_drops);
        report_test("capture and readback", errs);
    endtask

    task automatic test_full_drop();
        int errs;
        errs = n_errors;
        send_packet(2, 8'h01, 1'b0);
        send_packet(1, 8'hff, 1'b0);
        send_packet(4, 8'h0f, 1'b0);
        exp_drops = exp_drops + 32'd3;
        wait_drops(exp_drops);
        // Earlier packet must survive untouched
        check_stored();
        report_test("drops while full", errs);
    endtask

    task automatic test_release_mid();
        logic [WB_DATA_W-1:0] v;
        int                   errs;
        errs = n_errors;
        fork
            send_packet(10, 8'hff, 1'b0);
            begin
                repeat (3) @(posedge clk);
                wb_write(REG_CTRL, 32'd1);
            end
        join
        exp_drops = exp_drops + 32'd1;
        wait_drops(exp_drops);
        wb_read(REG_STATUS, v);
        check_reg("full flag", {31'b0, v[0]}, 32'd0);
        send_packet(6, 8'h3f, 1'b0);
        stored_q   = sent_q;
        stored_len = expected_len(6, 8'h3f);
        wait_full();
        check_stored();
        wb_read(REG_DROPS, v);
        check_reg("drop count", v, exp_drops);
        report_test("release during a packet", errs);
    endtask

    task automatic test_stalls();
        logic [WB_DATA_W-1:0] v;
        int                   errs;
        errs = n_errors;
        wb_write(REG_CTRL, 32'd1);
        // Short packet realigns the snooper to a boundary
        send_packet(1, 8'hff, 1'b0);
        exp_drops = exp_drops + 32'd1;
        n_stalls = 0;
        send_packet(8, 8'h1f, 1'b1);
        stored_q   = sent_q;
        stored_len = expected_len(8, 8'h1f);
        wait_full();
        check_stored();
        wb_read(REG_DROPS, v);
        check_reg("drop count", v, exp_drops);
        if (n_stalls == 0) begin
            n_errors++;
            $display("The stall pattern held no cycle with ready low");
        end
        report_test("idle beats not counted", errs);
    endtask

    initial begin
        lfsr_q     = LFSR_SEED;
        rst        = 1'b1;
        beat       = '0;
        tvalid     = 1'b0;
        tready     = 1'b0;
        wb_req     = '0;
        exp_drops  = '0;
        stored_len = '0;
        n_checks   = 0;
        n_errors   = 0;
        n_tests    = 0;
        n_failed   = 0;
        n_stalls   = 0;
        timed_out  = 1'b0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        repeat (2) @(posedge clk);
        test_first_drop();
        test_capture();
        test_full_drop();
        test_release_mid();
        test_stalls();
        $display("Tests %0d, failed %0d, checks %0d, errors %0d, timeout %0d",
                 n_tests, n_failed, n_checks, n_errors, timed_out);
        if (n_errors == 0 && !timed_out) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
design/snoop_pkg.sv
design/axis_snooper.sv
design/packet_buffer.sv
design/wb_snoop_regs.sv
design/snoop_top.sv
verif/snoop_assert.sv
verif/snoop_tb.sv

/* Makefile */
# Verilator build and run for the packet snooper testbench

TOP = snoop_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f verilog.f

# Pass only when the simulation output holds the pass line
run: compile
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^Simulation passed$$"

clean:
	rm -rf obj_dir
